// File: hw/soc_defines.svh
// address map, bus widths and reset values, included by the package and the bus RTL
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

`define SOC_ADDR_W 64
`define SOC_DATA_W 64
`define SOC_STRB_W 8

// CLINT occupies one 64 KiB region
`define SOC_CLINT_BASE 64'h0000_0000_0200_0000
`define SOC_CLINT_MASK 64'hFFFF_FFFF_FFFF_0000
`define SOC_MTIMECMP_ADDR 64'h0000_0000_0200_4000
`define SOC_MTIME_ADDR 64'h0000_0000_0200_BFF8

// all ones keeps the timer interrupt quiet out of reset
`define SOC_MTIMECMP_RST 64'hFFFF_FFFF_FFFF_FFFF

`endif

// File: hw/soc_pkg.sv
// AXI channel payload types, response codes and the byte-merge helper shared by the bus RTL
`include "soc_defines.svh"

package soc_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [`SOC_DATA_W-1:0] data;
        logic [`SOC_STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        resp_t resp;
    } axi_b_t;

    typedef struct packed {
        logic [`SOC_DATA_W-1:0] data;
        resp_t                  resp;
    } axi_r_t;

    // new bytes win where the strobe is set
    function automatic logic [`SOC_DATA_W-1:0] strb_merge(
        input logic [`SOC_DATA_W-1:0] old_word,
        input logic [`SOC_DATA_W-1:0] new_word,
        input logic [`SOC_STRB_W-1:0] strb
    );
        logic [`SOC_DATA_W-1:0] merged;
        merged = old_word;
        for (int i = 0; i < `SOC_STRB_W; i++) begin
            if (strb[i]) begin
                merged[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: hw/core_axi_master.sv
// turns the core's level load/store requests into single-beat AXI transactions
`timescale 1ns/1ps
`include "soc_defines.svh"

module core_axi_master (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic [`SOC_ADDR_W-1:0] i_req_addr,
    input  logic [`SOC_DATA_W-1:0] i_req_wdata,
    input  logic [`SOC_STRB_W-1:0] i_req_mask,
    input  logic                   i_req_we,
    input  logic                   i_req_re,
    output logic [`SOC_DATA_W-1:0] o_req_rdata,
    output logic                   o_req_finish,
    output soc_pkg::axi_aw_t       o_aw,
    output logic                   o_aw_valid,
    input  logic                   i_aw_ready,
    output soc_pkg::axi_w_t        o_w,
    output logic                   o_w_valid,
    input  logic                   i_w_ready,
    input  soc_pkg::axi_b_t        i_b,
    input  logic                   i_b_valid,
    output logic                   o_b_ready,
    output soc_pkg::axi_ar_t       o_ar,
    output logic                   o_ar_valid,
    input  logic                   i_ar_ready,
    input  soc_pkg::axi_r_t        i_r,
    input  logic                   i_r_valid,
    output logic                   o_r_ready
);

    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ, ST_DONE} state_t;

    state_t                 state;
    logic                   aw_valid_q;
    logic                   w_valid_q;
    logic                   ar_valid_q;
    logic [`SOC_ADDR_W-1:0] addr_q;
    logic [`SOC_DATA_W-1:0] wdata_q;
    logic [`SOC_STRB_W-1:0] mask_q;
    logic [`SOC_DATA_W-1:0] rdata_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
            ar_valid_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // store wins when both levels are up
                    if (i_req_we) begin
                        state      <= ST_WRITE;
                        aw_valid_q <= 1'b1;
                        w_valid_q  <= 1'b1;
                    end else if (i_req_re) begin
                        state      <= ST_READ;
                        ar_valid_q <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (i_aw_ready) begin
                        aw_valid_q <= 1'b0;
                    end
                    if (i_w_ready) begin
                        w_valid_q <= 1'b0;
                    end
                    if (i_b_valid) begin
                        state <= ST_DONE;
                    end
                end
                ST_READ: begin
                    if (i_ar_ready) begin
                        ar_valid_q <= 1'b0;
                    end
                    if (i_r_valid) begin
                        state <= ST_DONE;
                    end
                end
                // the core drops its level during the finish cycle
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            addr_q  <= i_req_addr;
            wdata_q <= i_req_wdata;
            mask_q  <= i_req_mask;
        end
        if (state == ST_READ && i_r_valid) begin
            rdata_q <= i_r.data;
        end
        // store completion reports the response code in the low bits
        if (state == ST_WRITE && i_b_valid) begin
            rdata_q <= {{(`SOC_DATA_W-2){1'b0}}, i_b.resp};
        end
    end

    assign o_aw.addr    = addr_q;
    assign o_aw_valid   = aw_valid_q;
    assign o_w.data     = wdata_q;
    assign o_w.strb     = mask_q;
    assign o_w_valid    = w_valid_q;
    assign o_b_ready    = (state == ST_WRITE);
    assign o_ar.addr    = addr_q;
    assign o_ar_valid   = ar_valid_q;
    assign o_r_ready    = (state == ST_READ);
    assign o_req_rdata  = rdata_q;
    assign o_req_finish = (state == ST_DONE);

endmodule

// File: hw/mmio_router.sv
// address decoder that steers AXI requests to the CLINT or the RAM bridge and muxes responses
`timescale 1ns/1ps
`include "soc_defines.svh"

module mmio_router (
    input  logic             clk,
    input  logic             i_rst_n,
    input  soc_pkg::axi_aw_t i_aw,
    input  logic             i_aw_valid,
    output logic             o_aw_ready,
    input  soc_pkg::axi_w_t  i_w,
    input  logic             i_w_valid,
    output logic             o_w_ready,
    output soc_pkg::axi_b_t  o_b,
    output logic             o_b_valid,
    input  logic             i_b_ready,
    input  soc_pkg::axi_ar_t i_ar,
    input  logic             i_ar_valid,
    output logic             o_ar_ready,
    output soc_pkg::axi_r_t  o_r,
    output logic             o_r_valid,
    input  logic             i_r_ready,
    output soc_pkg::axi_aw_t o_tim_aw,
    output logic             o_tim_aw_valid,
    input  logic             i_tim_aw_ready,
    output soc_pkg::axi_w_t  o_tim_w,
    output logic             o_tim_w_valid,
    input  logic             i_tim_w_ready,
    input  soc_pkg::axi_b_t  i_tim_b,
    input  logic             i_tim_b_valid,
    output logic             o_tim_b_ready,
    output soc_pkg::axi_ar_t o_tim_ar,
    output logic             o_tim_ar_valid,
    input  logic             i_tim_ar_ready,
    input  soc_pkg::axi_r_t  i_tim_r,
    input  logic             i_tim_r_valid,
    output logic             o_tim_r_ready,
    output soc_pkg::axi_aw_t o_ram_aw,
    output logic             o_ram_aw_valid,
    input  logic             i_ram_aw_ready,
    output soc_pkg::axi_w_t  o_ram_w,
    output logic             o_ram_w_valid,
    input  logic             i_ram_w_ready,
    input  soc_pkg::axi_b_t  i_ram_b,
    input  logic             i_ram_b_valid,
    output logic             o_ram_b_ready,
    output soc_pkg::axi_ar_t o_ram_ar,
    output logic             o_ram_ar_valid,
    input  logic             i_ram_ar_ready,
    input  soc_pkg::axi_r_t  i_ram_r,
    input  logic             i_ram_r_valid,
    output logic             o_ram_r_ready
);

    logic aw_is_tim;
    logic ar_is_tim;
    logic wr_sel_tim_q;
    logic rd_sel_tim_q;

    assign aw_is_tim = (i_aw.addr & `SOC_CLINT_MASK) == `SOC_CLINT_BASE;
    assign ar_is_tim = (i_ar.addr & `SOC_CLINT_MASK) == `SOC_CLINT_BASE;

    // payload fans out to both slaves and only the valid is steered
    assign o_tim_aw       = i_aw;
    assign o_ram_aw       = i_aw;
    assign o_tim_aw_valid = i_aw_valid && aw_is_tim;
    assign o_ram_aw_valid = i_aw_valid && !aw_is_tim;
    assign o_aw_ready     = aw_is_tim ? i_tim_aw_ready : i_ram_aw_ready;

    // W follows the AW address, which the master holds until B
    assign o_tim_w       = i_w;
    assign o_ram_w       = i_w;
    assign o_tim_w_valid = i_w_valid && aw_is_tim;
    assign o_ram_w_valid = i_w_valid && !aw_is_tim;
    assign o_w_ready     = aw_is_tim ? i_tim_w_ready : i_ram_w_ready;

    assign o_tim_ar       = i_ar;
    assign o_ram_ar       = i_ar;
    assign o_tim_ar_valid = i_ar_valid && ar_is_tim;
    assign o_ram_ar_valid = i_ar_valid && !ar_is_tim;
    assign o_ar_ready     = ar_is_tim ? i_tim_ar_ready : i_ram_ar_ready;

    // remember the target until the response comes back
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_sel_tim_q <= 1'b0;
            rd_sel_tim_q <= 1'b0;
        end else begin
            if (i_aw_valid && o_aw_ready) begin
                wr_sel_tim_q <= aw_is_tim;
            end
            if (i_ar_valid && o_ar_ready) begin
                rd_sel_tim_q <= ar_is_tim;
            end
        end
    end

    assign o_b           = wr_sel_tim_q ? i_tim_b : i_ram_b;
    assign o_b_valid     = wr_sel_tim_q ? i_tim_b_valid : i_ram_b_valid;
    assign o_tim_b_ready = i_b_ready && wr_sel_tim_q;
    assign o_ram_b_ready = i_b_ready && !wr_sel_tim_q;

    assign o_r           = rd_sel_tim_q ? i_tim_r : i_ram_r;
    assign o_r_valid     = rd_sel_tim_q ? i_tim_r_valid : i_ram_r_valid;
    assign o_tim_r_ready = i_r_ready && rd_sel_tim_q;
    assign o_ram_r_ready = i_r_ready && !rd_sel_tim_q;

endmodule

// File: hw/clint_timer.sv
// CLINT slave with mtime and mtimecmp registers, raises the machine timer interrupt
`timescale 1ns/1ps
`include "soc_defines.svh"

module clint_timer (
    input  logic             clk,
    input  logic             i_rst_n,
    input  soc_pkg::axi_aw_t i_aw,
    input  logic             i_aw_valid,
    output logic             o_aw_ready,
    input  soc_pkg::axi_w_t  i_w,
    input  logic             i_w_valid,
    output logic             o_w_ready,
    output soc_pkg::axi_b_t  o_b,
    output logic             o_b_valid,
    input  logic             i_b_ready,
    input  soc_pkg::axi_ar_t i_ar,
    input  logic             i_ar_valid,
    output logic             o_ar_ready,
    output soc_pkg::axi_r_t  o_r,
    output logic             o_r_valid,
    input  logic             i_r_ready,
    output logic             o_timer_intr
);

    logic [`SOC_DATA_W-1:0] mtime;
    logic [`SOC_DATA_W-1:0] mtimecmp;
    logic                   b_valid_q;
    logic                   r_valid_q;
    logic                   wr_fire;
    logic                   rd_fire;

    // AW and W are taken only as a pair
    assign wr_fire    = i_aw_valid && i_w_valid && !b_valid_q;
    assign rd_fire    = i_ar_valid && !r_valid_q;
    assign o_aw_ready = wr_fire;
    assign o_w_ready  = wr_fire;
    assign o_ar_ready = !r_valid_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mtime     <= '0;
            mtimecmp  <= `SOC_MTIMECMP_RST;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            // a write to mtime replaces this cycle's increment
            if (wr_fire && i_aw.addr == `SOC_MTIME_ADDR) begin
                mtime <= soc_pkg::strb_merge(mtime, i_w.data, i_w.strb);
            end else begin
                mtime <= mtime + 1'b1;
            end
            if (wr_fire && i_aw.addr == `SOC_MTIMECMP_ADDR) begin
                mtimecmp <= soc_pkg::strb_merge(mtimecmp, i_w.data, i_w.strb);
            end
            if (wr_fire) begin
                b_valid_q <= 1'b1;
            end else if (i_b_ready) begin
                b_valid_q <= 1'b0;
            end
            if (rd_fire) begin
                r_valid_q <= 1'b1;
            end else if (i_r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            o_b.resp <= (i_aw.addr == `SOC_MTIME_ADDR || i_aw.addr == `SOC_MTIMECMP_ADDR) ?
                        soc_pkg::RESP_OKAY : soc_pkg::RESP_SLVERR;
        end
        if (rd_fire) begin
            case (i_ar.addr)
                `SOC_MTIME_ADDR: begin
                    o_r.data <= mtime;
                    o_r.resp <= soc_pkg::RESP_OKAY;
                end
                `SOC_MTIMECMP_ADDR: begin
                    o_r.data <= mtimecmp;
                    o_r.resp <= soc_pkg::RESP_OKAY;
                end
                default: begin
                    o_r.data <= '0;
                    o_r.resp <= soc_pkg::RESP_SLVERR;
                end
            endcase
        end
    end

    assign o_b_valid    = b_valid_q;
    assign o_r_valid    = r_valid_q;
    assign o_timer_intr = (mtime >= mtimecmp);

endmodule

// File: hw/ram_port_bridge.sv
// AXI slave that sequences the external RAM read/write strobes, with read-merge-write stores
`timescale 1ns/1ps
`include "soc_defines.svh"

module ram_port_bridge (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  soc_pkg::axi_aw_t       i_aw,
    input  logic                   i_aw_valid,
    output logic                   o_aw_ready,
    input  soc_pkg::axi_w_t        i_w,
    input  logic                   i_w_valid,
    output logic                   o_w_ready,
    output soc_pkg::axi_b_t        o_b,
    output logic                   o_b_valid,
    input  logic                   i_b_ready,
    input  soc_pkg::axi_ar_t       i_ar,
    input  logic                   i_ar_valid,
    output logic                   o_ar_ready,
    output soc_pkg::axi_r_t        o_r,
    output logic                   o_r_valid,
    input  logic                   i_r_ready,
    output logic                   o_ram_read_ena,
    output logic [`SOC_ADDR_W-1:0] o_ram_addr,
    input  logic [`SOC_DATA_W-1:0] i_ram_rdata,
    output logic                   o_ram_write_ena,
    output logic [`SOC_ADDR_W-1:0] o_ram_write_addr,
    output logic [`SOC_DATA_W-1:0] o_ram_write_data
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_RD_STROBE, ST_RD_RESP, ST_WR_READ, ST_WR_WRITE, ST_WR_RESP
    } state_t;

    state_t                 state;
    logic                   wr_fire;
    logic                   rd_fire;
    logic [`SOC_ADDR_W-1:0] addr_q;
    logic [`SOC_DATA_W-1:0] wdata_q;
    logic [`SOC_STRB_W-1:0] strb_q;
    logic [`SOC_DATA_W-1:0] data_q;

    // a pending store blocks the read channel
    assign wr_fire    = (state == ST_IDLE) && i_aw_valid && i_w_valid;
    assign rd_fire    = (state == ST_IDLE) && i_ar_valid && !i_aw_valid;
    assign o_aw_ready = wr_fire;
    assign o_w_ready  = wr_fire;
    assign o_ar_ready = (state == ST_IDLE) && !i_aw_valid;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_fire) begin
                        state <= ST_WR_READ;
                    end else if (rd_fire) begin
                        state <= ST_RD_STROBE;
                    end
                end
                ST_RD_STROBE: state <= ST_RD_RESP;
                ST_RD_RESP:   state <= i_r_ready ? ST_IDLE : ST_RD_RESP;
                ST_WR_READ:   state <= ST_WR_WRITE;
                ST_WR_WRITE:  state <= ST_WR_RESP;
                default:      state <= i_b_ready ? ST_IDLE : ST_WR_RESP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            addr_q  <= i_aw.addr;
            wdata_q <= i_w.data;
            strb_q  <= i_w.strb;
        end else if (rd_fire) begin
            addr_q <= i_ar.addr;
        end
        // old word comes back in the strobe cycle
        if (state == ST_RD_STROBE) begin
            data_q <= i_ram_rdata;
        end
        if (state == ST_WR_READ) begin
            data_q <= soc_pkg::strb_merge(i_ram_rdata, wdata_q, strb_q);
        end
    end

    assign o_ram_read_ena   = (state == ST_RD_STROBE) || (state == ST_WR_READ);
    assign o_ram_addr       = addr_q;
    assign o_ram_write_ena  = (state == ST_WR_WRITE);
    assign o_ram_write_addr = addr_q;
    assign o_ram_write_data = data_q;

    assign o_r.data  = data_q;
    assign o_r.resp  = soc_pkg::RESP_OKAY;
    assign o_r_valid = (state == ST_RD_RESP);
    assign o_b.resp  = soc_pkg::RESP_OKAY;
    assign o_b_valid = (state == ST_WR_RESP);

endmodule

// File: hw/soc_top.sv
// top level of the MMIO data path: core-side master, address router, CLINT and RAM bridge
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_top (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic [`SOC_ADDR_W-1:0] i_req_addr,
    input  logic [`SOC_DATA_W-1:0] i_req_wdata,
    input  logic [`SOC_STRB_W-1:0] i_req_mask,
    input  logic                   i_req_we,
    input  logic                   i_req_re,
    output logic [`SOC_DATA_W-1:0] o_req_rdata,
    output logic                   o_req_finish,
    output logic                   o_ram_read_ena,
    output logic [`SOC_ADDR_W-1:0] o_ram_addr,
    input  logic [`SOC_DATA_W-1:0] i_ram_rdata,
    output logic                   o_ram_write_ena,
    output logic [`SOC_ADDR_W-1:0] o_ram_write_addr,
    output logic [`SOC_DATA_W-1:0] o_ram_write_data,
    output logic                   o_timer_intr
);

    soc_pkg::axi_aw_t mst_aw, tim_aw, ram_aw;
    soc_pkg::axi_w_t  mst_w, tim_w, ram_w;
    soc_pkg::axi_b_t  mst_b, tim_b, ram_b;
    soc_pkg::axi_ar_t mst_ar, tim_ar, ram_ar;
    soc_pkg::axi_r_t  mst_r, tim_r, ram_r;

    logic mst_aw_valid, mst_aw_ready, mst_w_valid, mst_w_ready, mst_b_valid, mst_b_ready;
    logic mst_ar_valid, mst_ar_ready, mst_r_valid, mst_r_ready;
    logic tim_aw_valid, tim_aw_ready, tim_w_valid, tim_w_ready, tim_b_valid, tim_b_ready;
    logic tim_ar_valid, tim_ar_ready, tim_r_valid, tim_r_ready;
    logic ram_aw_valid, ram_aw_ready, ram_w_valid, ram_w_ready, ram_b_valid, ram_b_ready;
    logic ram_ar_valid, ram_ar_ready, ram_r_valid, ram_r_ready;

    core_axi_master u_master (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata), .i_req_mask(i_req_mask),
        .i_req_we(i_req_we), .i_req_re(i_req_re),
        .o_req_rdata(o_req_rdata), .o_req_finish(o_req_finish),
        .o_aw(mst_aw), .o_aw_valid(mst_aw_valid), .i_aw_ready(mst_aw_ready),
        .o_w(mst_w), .o_w_valid(mst_w_valid), .i_w_ready(mst_w_ready),
        .i_b(mst_b), .i_b_valid(mst_b_valid), .o_b_ready(mst_b_ready),
        .o_ar(mst_ar), .o_ar_valid(mst_ar_valid), .i_ar_ready(mst_ar_ready),
        .i_r(mst_r), .i_r_valid(mst_r_valid), .o_r_ready(mst_r_ready)
    );

    mmio_router u_router (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_aw(mst_aw), .i_aw_valid(mst_aw_valid), .o_aw_ready(mst_aw_ready),
        .i_w(mst_w), .i_w_valid(mst_w_valid), .o_w_ready(mst_w_ready),
        .o_b(mst_b), .o_b_valid(mst_b_valid), .i_b_ready(mst_b_ready),
        .i_ar(mst_ar), .i_ar_valid(mst_ar_valid), .o_ar_ready(mst_ar_ready),
        .o_r(mst_r), .o_r_valid(mst_r_valid), .i_r_ready(mst_r_ready),
        .o_tim_aw(tim_aw), .o_tim_aw_valid(tim_aw_valid), .i_tim_aw_ready(tim_aw_ready),
        .o_tim_w(tim_w), .o_tim_w_valid(tim_w_valid), .i_tim_w_ready(tim_w_ready),
        .i_tim_b(tim_b), .i_tim_b_valid(tim_b_valid), .o_tim_b_ready(tim_b_ready),
        .o_tim_ar(tim_ar), .o_tim_ar_valid(tim_ar_valid), .i_tim_ar_ready(tim_ar_ready),
        .i_tim_r(tim_r), .i_tim_r_valid(tim_r_valid), .o_tim_r_ready(tim_r_ready),
        .o_ram_aw(ram_aw), .o_ram_aw_valid(ram_aw_valid), .i_ram_aw_ready(ram_aw_ready),
        .o_ram_w(ram_w), .o_ram_w_valid(ram_w_valid), .i_ram_w_ready(ram_w_ready),
        .i_ram_b(ram_b), .i_ram_b_valid(ram_b_valid), .o_ram_b_ready(ram_b_ready),
        .o_ram_ar(ram_ar), .o_ram_ar_valid(ram_ar_valid), .i_ram_ar_ready(ram_ar_ready),
        .i_ram_r(ram_r), .i_ram_r_valid(ram_r_valid), .o_ram_r_ready(ram_r_ready)
    );

    clint_timer u_clint (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_aw(tim_aw), .i_aw_valid(tim_aw_valid), .o_aw_ready(tim_aw_ready),
        .i_w(tim_w), .i_w_valid(tim_w_valid), .o_w_ready(tim_w_ready),
        .o_b(tim_b), .o_b_valid(tim_b_valid), .i_b_ready(tim_b_ready),
        .i_ar(tim_ar), .i_ar_valid(tim_ar_valid), .o_ar_ready(tim_ar_ready),
        .o_r(tim_r), .o_r_valid(tim_r_valid), .i_r_ready(tim_r_ready),
        .o_timer_intr(o_timer_intr)
    );

    ram_port_bridge u_ram_bridge (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_aw(ram_aw), .i_aw_valid(ram_aw_valid), .o_aw_ready(ram_aw_ready),
        .i_w(ram_w), .i_w_valid(ram_w_valid), .o_w_ready(ram_w_ready),
        .o_b(ram_b), .o_b_valid(ram_b_valid), .i_b_ready(ram_b_ready),
        .i_ar(ram_ar), .i_ar_valid(ram_ar_valid), .o_ar_ready(ram_ar_ready),
        .o_r(ram_r), .o_r_valid(ram_r_valid), .i_r_ready(ram_r_ready),
        .o_ram_read_ena(o_ram_read_ena), .o_ram_addr(o_ram_addr), .i_ram_rdata(i_ram_rdata),
        .o_ram_write_ena(o_ram_write_ena), .o_ram_write_addr(o_ram_write_addr),
        .o_ram_write_data(o_ram_write_data)
    );

endmodule

// File: verif/tb_soc_top.sv
// directed testbench for soc_top with a sparse RAM model; run through list.f with Verilator
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_soc_top;

    localparam int ACCESS_TIMEOUT = 100;
    localparam int INTR_TIMEOUT   = 500;
    localparam logic [63:0] RAM_ADDR_A = 64'h0000_0000_8000_0040;
    localparam logic [63:0] RAM_ADDR_B = 64'h0000_0000_8000_0108;
    localparam logic [63:0] CLINT_HOLE = 64'h0000_0000_0200_0100;

    logic                   clk;
    logic                   i_rst_n;
    logic [`SOC_ADDR_W-1:0] i_req_addr;
    logic [`SOC_DATA_W-1:0] i_req_wdata;
    logic [`SOC_STRB_W-1:0] i_req_mask;
    logic                   i_req_we;
    logic                   i_req_re;
    logic [`SOC_DATA_W-1:0] o_req_rdata;
    logic                   o_req_finish;
    logic                   o_ram_read_ena;
    logic [`SOC_ADDR_W-1:0] o_ram_addr;
    logic [`SOC_DATA_W-1:0] i_ram_rdata;
    logic                   o_ram_write_ena;
    logic [`SOC_ADDR_W-1:0] o_ram_write_addr;
    logic [`SOC_DATA_W-1:0] o_ram_write_data;
    logic                   o_timer_intr;

    logic [63:0] ram_mem [logic [63:0]];
    logic [63:0] wr_addr_seen;
    bit          wr_seen;
    int          seed = 8989;
    int          pass_count = 0;
    int          fail_count = 0;

    soc_top i_soc_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // untouched words come from a pattern over the whole address
    function automatic logic [63:0] fill_word(input logic [63:0] addr);
        return addr ^ {addr[31:0], addr[63:32]} ^ 64'hC3A5_96E1_0F5A_7B2D;
    endfunction

    function automatic logic [63:0] ram_word(input logic [63:0] addr);
        if (ram_mem.exists(addr)) begin
            return ram_mem[addr];
        end
        return fill_word(addr);
    endfunction

    // bytes of new_word replace old_word where the mask bit is set
    function automatic logic [63:0] masked_word(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0]  mask);
        logic [63:0] bit_mask;
        for (int b = 0; b < 64; b++) begin
            bit_mask[b] = mask[b / 8];
        end
        return (old_word & ~bit_mask) | (new_word & bit_mask);
    endfunction

    // read data follows o_ram_addr only while the read strobe is up
    always @(negedge clk) begin
        if (o_ram_read_ena) begin
            i_ram_rdata = ram_word(o_ram_addr);
        end else begin
            i_ram_rdata = '0;
        end
    end

    always @(posedge clk) begin
        if (o_ram_write_ena) begin
            ram_mem[o_ram_write_addr] = o_ram_write_data;
            wr_addr_seen = o_ram_write_addr;
            wr_seen = 1'b1;
        end
    end

    task automatic check_value(input string test, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) begin
            pass_count++;
        end else begin
            $display("FAIL %s expected %h actual %h", test, expected, actual);
            fail_count++;
        end
    endtask

    task automatic check_true(input string test, input bit cond, input string what);
        assert (cond) begin
            pass_count++;
        end else begin
            $display("FAIL %s failed because %s", test, what);
            fail_count++;
        end
    endtask

    task automatic report_test(input string test, input int fails_before);
        if (fail_count == fails_before) begin
            $display("test %s ok", test);
        end else begin
            $display("test %s had %0d errors", test, fail_count - fails_before);
        end
    endtask

    // one core request held until o_req_finish
    task automatic do_access(input logic is_write, input logic [63:0] addr,
                             input logic [63:0] wdata, input logic [7:0] mask,
                             output logic [63:0] rdata);
        int waited;
        bit seen;
        waited = 0;
        seen = 1'b0;
        @(negedge clk);
        i_req_addr  = addr;
        i_req_wdata = wdata;
        i_req_mask  = mask;
        i_req_we    = is_write;
        i_req_re    = !is_write;
        while (!seen && waited < ACCESS_TIMEOUT) begin
            @(negedge clk);
            waited++;
            seen = o_req_finish;
        end
        rdata    = o_req_rdata;
        i_req_we = 1'b0;
        i_req_re = 1'b0;
        if (!seen) begin
            $display("access to %h got no o_req_finish within %0d cycles", addr, waited);
            fail_count++;
        end
    endtask

    task automatic test_reset_state();
        int f0;
        f0 = fail_count;
        check_value("reset_state", 64'd0, {63'd0, o_ram_read_ena});
        check_value("reset_state", 64'd0, {63'd0, o_ram_write_ena});
        check_value("reset_state", 64'd0, {63'd0, o_req_finish});
        check_value("reset_state", 64'd0, {63'd0, o_timer_intr});
        report_test("reset_state", f0);
    endtask

    task automatic test_ram_full_store();
        int          f0;
        logic [63:0] data;
        logic [63:0] rd;
        f0 = fail_count;
        data = {$random(seed), $random(seed)};
        wr_seen = 1'b0;
        do_access(1'b1, RAM_ADDR_A, data, 8'hFF, rd);
        check_true("ram_full_store", wr_seen, "no RAM write strobe was seen");
        check_value("ram_full_store", RAM_ADDR_A, wr_addr_seen);
        do_access(1'b0, RAM_ADDR_A, 64'd0, 8'h00, rd);
        check_value("ram_full_store", data, rd);
        report_test("ram_full_store", f0);
    endtask

    task automatic test_ram_partial_store();
        int          f0;
        logic [63:0] data;
        logic [63:0] expected;
        logic [63:0] rd;
        f0 = fail_count;
        data = {$random(seed), $random(seed)};
        expected = masked_word(ram_word(RAM_ADDR_B), data, 8'b0101_1001);
        do_access(1'b1, RAM_ADDR_B, data, 8'b0101_1001, rd);
        do_access(1'b0, RAM_ADDR_B, 64'd0, 8'h00, rd);
        check_value("ram_partial_store", expected, rd);
        report_test("ram_partial_store", f0);
    endtask

    task automatic test_mtime_counts();
        int          f0;
        logic [63:0] t0;
        logic [63:0] t1;
        f0 = fail_count;
        do_access(1'b0, `SOC_MTIME_ADDR, 64'd0, 8'h00, t0);
        do_access(1'b0, `SOC_MTIME_ADDR, 64'd0, 8'h00, t1);
        check_true("mtime_counts", t1 > t0, "the second mtime read did not exceed the first");
        report_test("mtime_counts", f0);
    endtask

    task automatic test_timer_intr();
        int          f0;
        int          waited;
        logic [63:0] now;
        logic [63:0] rd;
        f0 = fail_count;
        do_access(1'b0, `SOC_MTIME_ADDR, 64'd0, 8'h00, now);
        do_access(1'b1, `SOC_MTIMECMP_ADDR, now + 64'd200, 8'hFF, rd);
        check_value("timer_intr", 64'd0, {63'd0, o_timer_intr});
        waited = 0;
        while (!o_timer_intr && waited < INTR_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        check_true("timer_intr", o_timer_intr, "the interrupt never rose after mtimecmp");
        do_access(1'b1, `SOC_MTIMECMP_ADDR, `SOC_MTIMECMP_RST, 8'hFF, rd);
        check_value("timer_intr", 64'd0, {63'd0, o_timer_intr});
        report_test("timer_intr", f0);
    endtask

    task automatic test_clint_hole();
        int          f0;
        logic [63:0] t0;
        logic [63:0] t1;
        logic [63:0] rd;
        f0 = fail_count;
        do_access(1'b0, `SOC_MTIME_ADDR, 64'd0, 8'h00, t0);
        do_access(1'b1, CLINT_HOLE, {$random(seed), $random(seed)}, 8'hFF, rd);
        do_access(1'b0, `SOC_MTIME_ADDR, 64'd0, 8'h00, t1);
        // only a few dozen clocks pass between the two reads
        check_true("clint_hole", t1 > t0 && t1 - t0 < 64, "mtime jumped after the stray store");
        do_access(1'b0, `SOC_MTIMECMP_ADDR, 64'd0, 8'h00, rd);
        check_value("clint_hole", `SOC_MTIMECMP_RST, rd);
        do_access(1'b0, CLINT_HOLE, 64'd0, 8'h00, rd);
        check_value("clint_hole", 64'd0, rd);
        report_test("clint_hole", f0);
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_req_addr  = '0;
        i_req_wdata = '0;
        i_req_mask  = '0;
        i_req_we    = 1'b0;
        i_req_re    = 1'b0;
        i_ram_rdata = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        test_reset_state();
        test_ram_full_store();
        test_ram_partial_store();
        test_mtime_counts();
        test_timer_intr();
        test_clint_hole();
        $display("checks passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
hw/soc_pkg.sv
hw/core_axi_master.sv
hw/mmio_router.sv
hw/clint_timer.sv
hw/ram_port_bridge.sv
hw/soc_top.sv
verif/tb_soc_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module tb_soc_top \
    -f list.f \
    --Mdir obj_dir -o tb_soc_top

./obj_dir/tb_soc_top | tee sim.log

if grep -qx ">>> PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
